// ==== Bender.yml ====
package:
  name: lenet_mac

sources:
  - verilog/lenet_pkg.sv
  - verilog/mac_stage_if.sv
  - verilog/lenet_xwyf_17.sv
  - verilog/mac_decode.sv
  - verilog/mac_execute.sv
  - verilog/mac_result.sv
  - verilog/lenet_mac_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_lenet_mac.sv

// ==== all.f ====
+incdir+tests
verilog/lenet_pkg.sv
verilog/mac_stage_if.sv
verilog/lenet_xwyf_17.sv
verilog/mac_decode.sv
verilog/mac_execute.sv
verilog/mac_result.sv
verilog/lenet_mac_top.sv
tests/tb_lenet_mac.sv

// ==== tests/tb_lenet_model.svh ====
`ifndef TB_LENET_MODEL_SVH
`define TB_LENET_MODEL_SVH

lenet_pkg::acc_t model_acc;  // mirrors the engine accumulator

function automatic int unsigned place_bit(input logic b, input int unsigned pos);
    return b ? (32'd1 << pos) : 32'd0;
endfunction

// approximate product, summed term by term from the partial-row table
function automatic lenet_pkg::product_t approx_product(
    input lenet_pkg::pixel_t  x,
    input lenet_pkg::weight_t y
);
    logic [7:0]  p [8];
    int unsigned sum;
    for (int i = 0; i < 8; i++) begin
        p[i] = x[i] ? y : 8'h00;
    end
    sum = (32'(p[6]) << 6) + (32'(p[7]) << 7);  // exact rows
    sum += place_bit(p[4][7] & p[5][6], 12) + place_bit(p[4][6] & p[5][5], 11)
         + place_bit(p[3][7], 10) + place_bit(p[2][7] | p[3][6], 9)
         + place_bit(p[1][7], 8) + place_bit(p[0][7] ^ p[1][6], 7)
         + place_bit(p[0][6] | p[1][5], 6) + place_bit(p[0][3] | p[1][2], 4)
         + place_bit(p[0][2] ^ p[1][1], 2);
    sum += place_bit(p[5][7], 12) + place_bit(p[4][7] ^ p[5][6], 11)
         + place_bit(p[4][5] & p[5][4], 10) + place_bit(p[4][5] ^ p[5][4], 9)
         + place_bit(p[2][5] & p[3][4], 8) + place_bit(p[2][5] ^ p[3][4], 7)
         + place_bit(p[2][4] | p[3][3], 6);
    sum += place_bit(p[4][6] ^ p[5][5], 10) + place_bit(p[2][6] | p[3][5], 8)
         + place_bit(p[4][2] | p[5][1], 7) + place_bit(p[4][2] | p[5][1], 6);
    sum += place_bit(p[4][3] & p[5][2], 8) + place_bit(p[4][3] | p[5][2], 7)
         + place_bit(p[4][4] & p[5][3], 8) + place_bit(p[4][4] | p[5][3], 8);
    return lenet_pkg::product_t'(sum);  // wraps at 16 bits
endfunction

// returns {sat, data}
function automatic logic [8:0] requantise(input lenet_pkg::acc_t acc,
                                          input lenet_pkg::shift_t shift);
    lenet_pkg::acc_t shifted;
    shifted = acc >> shift;
    if (shifted > lenet_pkg::acc_t'(lenet_pkg::RESULT_MAX)) begin
        return {1'b1, lenet_pkg::result_t'(lenet_pkg::RESULT_MAX)};
    end
    return {1'b0, shifted[7:0]};
endfunction

`endif

// ==== tests/tb_lenet_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lenet_mac;

    localparam time         CLK_PERIOD    = 100ns;
    localparam int unsigned RESET_CYCLES  = 16;
    localparam int unsigned NUM_WINDOWS   = 8;
    localparam int unsigned KERNEL_TAPS   = 25;  // 5x5 kernel
    localparam int unsigned NUM_PIPE      = 4;
    // idle cycles count as commands here
    localparam int unsigned TOTAL_CMDS    = 20 + 15 + NUM_WINDOWS * (KERNEL_TAPS + 2)
                                          + 8 + NUM_PIPE * 3;
    localparam int unsigned MARGIN_CYCLES = RESET_CYCLES + 120;

    logic               clk;
    logic               rst_n;
    logic               cmd_valid;
    lenet_pkg::mac_op_e cmd_op;
    lenet_pkg::pixel_t  cmd_a;
    lenet_pkg::weight_t cmd_b;
    logic               res_valid;
    lenet_pkg::result_t res_data;
    logic               res_sat;

    longint unsigned    cycle_count;
    lenet_pkg::result_t exp_data_q [$];
    logic               exp_sat_q [$];
    longint unsigned    exp_due_q [$];
    logic               head_valid;
    lenet_pkg::result_t head_data;
    logic               head_sat;
    longint unsigned    head_due;
    int                 errors;
    int                 checked;
    int                 tests_passed;
    int                 tests_failed;

    `include "tb_lenet_model.svh"

    lenet_mac_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_sat   (res_sat)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    check_data: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid && head_valid) |-> (res_data == head_data))
    else begin
        errors++;
        $display("Mismatch at %0t: res_data expected %0d, actual %0d",
                 $time, $sampled(head_data), $sampled(res_data));
    end

    check_sat: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid && head_valid) |-> (res_sat == head_sat))
    else begin
        errors++;
        $display("Mismatch at %0t: res_sat expected %0b, actual %0b",
                 $time, $sampled(head_sat), $sampled(res_sat));
    end

    check_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (head_valid && head_due == cycle_count))
    else begin
        errors++;
        $display("res_valid was high at %0t although no result was due", $time);
    end

    check_missing: assert property (@(posedge clk) disable iff (!rst_n)
        (head_valid && head_due == cycle_count) |-> res_valid)
    else begin
        errors++;
        $display("a result due at %0t did not arrive on res_valid", $time);
    end

    // retire the head once its cycle is over
    always @(posedge clk) begin
        if (head_valid && head_due == cycle_count) begin
            void'(exp_data_q.pop_front());
            void'(exp_sat_q.pop_front());
            void'(exp_due_q.pop_front());
            checked++;
            refresh_head();
        end
    end

    function automatic void refresh_head();
        head_valid = (exp_due_q.size() != 0);
        if (head_valid) begin
            head_data = exp_data_q[0];
            head_sat  = exp_sat_q[0];
            head_due  = exp_due_q[0];
        end
    endfunction

    task automatic issue_cmd(input lenet_pkg::mac_op_e op, input lenet_pkg::pixel_t a,
                             input lenet_pkg::weight_t b);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_a     = a;
        cmd_b     = b;
    endtask

    task automatic load_bias(input lenet_pkg::bias_t bias);
        issue_cmd(lenet_pkg::OP_CLEAR, bias[15:8], bias[7:0]);
        model_acc = lenet_pkg::acc_t'(bias);
    endtask

    task automatic accumulate(input lenet_pkg::pixel_t a, input lenet_pkg::weight_t b);
        issue_cmd(lenet_pkg::OP_MAC, a, b);
        model_acc = model_acc + lenet_pkg::acc_t'(approx_product(a, b));
    endtask

    task automatic request_result(input lenet_pkg::shift_t shift,
                                  input lenet_pkg::result_t data, input logic sat);
        issue_cmd(lenet_pkg::OP_FINISH, lenet_pkg::pixel_t'($urandom),
                  {3'($urandom), shift});  // top bits of b are ignored
        exp_data_q.push_back(data);
        exp_sat_q.push_back(sat);
        exp_due_q.push_back(cycle_count + lenet_pkg::MAC_LATENCY);
        refresh_head();
    endtask

    task automatic finish_window(input lenet_pkg::shift_t shift);
        logic [8:0] quant;
        quant = requantise(model_acc, shift);
        request_result(shift, quant[7:0], quant[8]);
    endtask

    task automatic idle_for(input int unsigned n);
        repeat (n) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            cmd_op    = lenet_pkg::mac_op_e'($urandom_range(3, 0));  // must be ignored
            cmd_a     = lenet_pkg::pixel_t'($urandom);
            cmd_b     = lenet_pkg::weight_t'($urandom);
        end
    endtask

    task automatic drain_results();
        idle_for(1);
        while (head_valid) begin
            @(posedge clk);
        end
        idle_for(3);  // room for a late or extra strobe
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int                 mark;
        lenet_pkg::pixel_t  a;
        lenet_pkg::weight_t b;
        logic [8:0]         quant;
        void'($urandom(67776));
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = lenet_pkg::OP_NOP;
        cmd_a        = '0;
        cmd_b        = '0;
        cycle_count  = 0;
        errors       = 0;
        checked      = 0;
        tests_passed = 0;
        tests_failed = 0;
        model_acc    = '0;
        refresh_head();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        idle_for(10);
        repeat (10) begin
            issue_cmd(lenet_pkg::OP_NOP, lenet_pkg::pixel_t'($urandom),
                      lenet_pkg::weight_t'($urandom));
        end
        drain_results();
        close_test("idle_and_nop", mark);

        mark = errors;
        for (int i = 1; i <= 3; i++) begin
            a = lenet_pkg::pixel_t'(i << 6);  // low six bits zero, product is exact
            b = lenet_pkg::weight_t'($urandom_range(255, 1));
            load_bias(16'h0000);
            accumulate(a, b);
            quant = requantise(lenet_pkg::acc_t'(32'(a) * 32'(b)), 5'd8);
            request_result(5'd8, quant[7:0], quant[8]);
        end
        load_bias(16'h0000);
        accumulate(8'h00, lenet_pkg::weight_t'($urandom_range(255, 1)));
        request_result(lenet_pkg::shift_t'($urandom), 8'd0, 1'b0);
        load_bias(16'h0000);
        accumulate(lenet_pkg::pixel_t'($urandom_range(255, 1)), 8'h00);
        request_result(lenet_pkg::shift_t'($urandom), 8'd0, 1'b0);
        drain_results();
        close_test("exact_products", mark);

        mark = errors;
        for (int w = 0; w < NUM_WINDOWS; w++) begin
            load_bias(lenet_pkg::bias_t'($urandom));
            repeat (KERNEL_TAPS) begin
                accumulate(lenet_pkg::pixel_t'($urandom), lenet_pkg::weight_t'($urandom));
            end
            finish_window(lenet_pkg::shift_t'($urandom_range(20, 4)));
        end
        drain_results();
        close_test("random_windows", mark);

        mark = errors;
        load_bias(16'hFFFF);
        request_result(5'd0, 8'd255, 1'b1);
        load_bias(16'h0100);  // just above the ceiling
        request_result(5'd0, 8'd255, 1'b1);
        load_bias(16'h00FF);
        request_result(5'd0, 8'd255, 1'b0);
        load_bias(16'h1234);
        request_result(5'd8, 8'h12, 1'b0);
        drain_results();
        close_test("saturation", mark);

        mark = errors;
        load_bias(16'h0000);
        accumulate(8'hC0, 8'hFF);
        finish_window(5'd8);  // 191 only if the mac was seen
        repeat (NUM_PIPE - 1) begin
            load_bias(lenet_pkg::bias_t'($urandom_range(255, 0)));
            accumulate(lenet_pkg::pixel_t'($urandom), lenet_pkg::weight_t'($urandom));
            finish_window(5'd8);
        end
        drain_results();
        close_test("back_to_back", mark);

        $display("tests passed %0d, failed %0d, results checked %0d, errors %0d",
                 tests_passed, tests_failed, checked, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((2 * TOTAL_CMDS + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired at %0t, the run did not complete", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/lenet_mac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lenet_mac_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cmd_valid,
    input  lenet_pkg::mac_op_e  cmd_op,
    input  lenet_pkg::pixel_t   cmd_a,
    input  lenet_pkg::weight_t  cmd_b,
    output logic                res_valid,
    output lenet_pkg::result_t  res_data,
    output logic                res_sat
);

    mac_stage_if dec_bus ();  // decode to execute
    mac_stage_if exe_bus ();  // execute to result

    mac_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .dec       (dec_bus.src)
    );

    mac_execute execute_i (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec_bus.dst),
        .exe   (exe_bus.src)
    );

    mac_result result_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe       (exe_bus.dst),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_sat   (res_sat)
    );

endmodule

`default_nettype wire

// ==== verilog/lenet_pkg.sv ====
`default_nettype none

package lenet_pkg;

    localparam int unsigned PIXEL_W   = 8;
    localparam int unsigned WEIGHT_W  = 8;
    localparam int unsigned PRODUCT_W = 16;
    localparam int unsigned BIAS_W    = 16;
    localparam int unsigned ACC_W     = 24;  // 16-bit bias plus 255 products
    localparam int unsigned SHIFT_W   = 5;
    localparam int unsigned RESULT_W  = 8;

    // command strobe to result strobe, in cycles
    localparam int unsigned MAC_LATENCY = 4;
    localparam int unsigned RESULT_MAX  = 255;  // saturation ceiling

    typedef logic [PIXEL_W-1:0]   pixel_t;
    typedef logic [WEIGHT_W-1:0]  weight_t;
    typedef logic [PRODUCT_W-1:0] product_t;
    typedef logic [BIAS_W-1:0]    bias_t;
    typedef logic [ACC_W-1:0]     acc_t;
    typedef logic [SHIFT_W-1:0]   shift_t;
    typedef logic [RESULT_W-1:0]  result_t;

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_CLEAR  = 2'd1,  // load bias
        OP_MAC    = 2'd2,
        OP_FINISH = 2'd3   // requantise and return
    } mac_op_e;

endpackage

`default_nettype wire

// ==== verilog/lenet_xwyf_17.sv ====
`timescale 1ns/1ps
`default_nettype none

module lenet_xwyf_17 (
    input  lenet_pkg::pixel_t   x,
    input  lenet_pkg::weight_t  y,
    output lenet_pkg::product_t z
);

    lenet_pkg::weight_t pp [8];  // partial rows, one per bit of x

    logic [12:0] w1;
    logic [12:0] w2;
    logic [12:0] w3;
    logic [12:0] w4;
    logic [12:0] w5;
    logic [12:0] w6;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // rows 1 to 6 squeezed into six sparse words

    assign w1 = {
        pp[4][7] & pp[5][6],
        pp[4][6] & pp[5][5],
        pp[3][7],
        pp[2][7] | pp[3][6],
        pp[1][7],
        pp[0][7] ^ pp[1][6],
        pp[0][6] | pp[1][5],
        1'b0,
        pp[0][3] | pp[1][2],
        1'b0,
        pp[0][2] ^ pp[1][1],
        2'b00
    };

    assign w2 = {
        pp[5][7],
        pp[4][7] ^ pp[5][6],
        pp[4][5] & pp[5][4],  // carry of bit 9
        pp[4][5] ^ pp[5][4],
        pp[2][5] & pp[3][4],
        pp[2][5] ^ pp[3][4],
        pp[2][4] | pp[3][3],
        6'b000000
    };

    assign w3 = {
        2'b00,
        pp[4][6] ^ pp[5][5],
        1'b0,
        pp[2][6] | pp[3][5],
        pp[4][2] | pp[5][1],  // same term on bits 7 and 6
        pp[4][2] | pp[5][1],
        6'b000000
    };

    assign w4 = {
        4'b0000,
        pp[4][3] & pp[5][2],
        pp[4][3] | pp[5][2],
        7'b0000000
    };

    assign w5 = {
        4'b0000,
        pp[4][4] & pp[5][3],
        8'b00000000
    };

    assign w6 = {
        4'b0000,
        pp[4][4] | pp[5][3],
        8'b00000000
    };

    // top two rows go in exactly
    assign z = lenet_pkg::product_t'({pp[6], 6'b000000})
             + lenet_pkg::product_t'({pp[7], 7'b0000000})
             + lenet_pkg::product_t'(w1)
             + lenet_pkg::product_t'(w2)
             + lenet_pkg::product_t'(w3)
             + lenet_pkg::product_t'(w4)
             + lenet_pkg::product_t'(w5)
             + lenet_pkg::product_t'(w6);

endmodule

`default_nettype wire

// ==== verilog/mac_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_decode (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cmd_valid,
    input  lenet_pkg::mac_op_e   cmd_op,
    input  lenet_pkg::pixel_t    cmd_a,
    input  lenet_pkg::weight_t   cmd_b,
    mac_stage_if.src             dec
);

    logic is_clear;
    logic is_mac;
    logic is_finish;

    assign is_clear  = cmd_valid && (cmd_op == lenet_pkg::OP_CLEAR);
    assign is_mac    = cmd_valid && (cmd_op == lenet_pkg::OP_MAC);
    assign is_finish = cmd_valid && (cmd_op == lenet_pkg::OP_FINISH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec.strobe <= 1'b0;
            dec.clear  <= 1'b0;
            dec.mac    <= 1'b0;
            dec.finish <= 1'b0;
        end else begin
            dec.strobe <= is_clear || is_mac || is_finish;  // nop gives nothing
            dec.clear  <= is_clear;
            dec.mac    <= is_mac;
            dec.finish <= is_finish;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            dec.pixel  <= cmd_a;
            dec.weight <= cmd_b;
            dec.bias   <= {cmd_a, cmd_b};  // a is the high byte
            dec.shift  <= cmd_b[lenet_pkg::SHIFT_W-1:0];
        end
    end

    // accumulator does not exist yet at this stage
    assign dec.acc = '0;

endmodule

`default_nettype wire

// ==== verilog/mac_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_execute (
    input  wire      clk,
    input  wire      rst_n,
    mac_stage_if.dst dec,
    mac_stage_if.src exe
);

    lenet_pkg::product_t prod;

    logic                s1_strobe;
    logic                s1_clear;
    logic                s1_mac;
    logic                s1_finish;
    lenet_pkg::product_t s1_prod;
    lenet_pkg::bias_t    s1_bias;
    lenet_pkg::shift_t   s1_shift;

    lenet_pkg::acc_t     acc;

    lenet_xwyf_17 mult_i (
        .x (dec.pixel),
        .y (dec.weight),
        .z (prod)
    );

    // stage 2: product register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_strobe <= 1'b0;
            s1_clear  <= 1'b0;
            s1_mac    <= 1'b0;
            s1_finish <= 1'b0;
        end else begin
            s1_strobe <= dec.strobe;
            s1_clear  <= dec.strobe && dec.clear;
            s1_mac    <= dec.strobe && dec.mac;
            s1_finish <= dec.strobe && dec.finish;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.strobe) begin
            s1_prod  <= prod;
            s1_bias  <= dec.bias;
            s1_shift <= dec.shift;
        end
    end

    // stage 3: accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc        <= '0;
            exe.strobe <= 1'b0;
            exe.finish <= 1'b0;
        end else begin
            exe.strobe <= s1_strobe && s1_finish;  // only finish moves on
            exe.finish <= s1_strobe && s1_finish;
            if (s1_strobe && s1_clear) begin
                acc <= lenet_pkg::acc_t'(s1_bias);
            end else if (s1_strobe && s1_mac) begin
                acc <= acc + lenet_pkg::acc_t'(s1_prod);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_strobe && s1_finish) begin
            exe.acc   <= acc;  // includes a mac from the cycle before
            exe.shift <= s1_shift;
        end
    end

    assign exe.clear  = 1'b0;
    assign exe.mac    = 1'b0;
    assign exe.pixel  = '0;
    assign exe.weight = '0;
    assign exe.bias   = '0;

endmodule

`default_nettype wire

// ==== verilog/mac_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_result (
    input  wire                 clk,
    input  wire                 rst_n,
    mac_stage_if.dst            exe,
    output logic                res_valid,
    output lenet_pkg::result_t  res_data,
    output logic                res_sat
);

    lenet_pkg::acc_t shifted;
    logic            over;
    logic            fire;

    assign shifted = exe.acc >> exe.shift;
    assign over    = shifted > lenet_pkg::acc_t'(lenet_pkg::RESULT_MAX);
    assign fire    = exe.strobe && exe.finish;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= fire;  // single cycle, never stalled
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_sat <= over;
            if (over) begin
                res_data <= lenet_pkg::result_t'(lenet_pkg::RESULT_MAX);
            end else begin
                res_data <= shifted[lenet_pkg::RESULT_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mac_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mac_stage_if;

    logic               strobe;  // one cycle per command
    logic               clear;
    logic               mac;
    logic               finish;
    lenet_pkg::pixel_t  pixel;
    lenet_pkg::weight_t weight;
    lenet_pkg::bias_t   bias;
    lenet_pkg::shift_t  shift;
    lenet_pkg::acc_t    acc;

    modport src (
        output strobe, clear, mac, finish,
        output pixel, weight, bias, shift, acc
    );

    modport dst (
        input strobe, clear, mac, finish,
        input pixel, weight, bias, shift, acc
    );

endinterface

`default_nettype wire
